/* src.f */
+incdir+common
common/decoder_pkg.sv
common/wb_if.sv
decoder/decoder_regs.sv
decoder/biphase_to_nrz.sv
decoder/mark_space_decode.sv
decoder/iq_output_select.sv
decoder/derandomizer.sv
decoder/decoder_top.sv
sim/decoder_tb.sv

/* run.sh */
#!/bin/sh
# Compile the decoder testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" \
  && rm -f sim.log \
  && verilator --binary --timing --top-module decoder_tb -f src.f -o decoder_sim \
  && ./obj_dir/decoder_sim > sim.log \
  && cat sim.log \
  && grep -q "^Simulation passed$" sim.log \
  && echo "Run result: PASS" \
  || { cat sim.log 2>/dev/null; echo "Run result: FAIL"; exit 1; }

/* sim/decoder_tb.sv */
// Testbench for the PCM symbol decoder top level
// Checks the register block, then streams random symbols through every line
// code, biphase, QPSK demux and RNRZ setting against a bit-level model
`include "decoder_cfg.svh"

module decoder_tb;
  import decoder_pkg::*;

  typedef struct packed {
    logic [8:0] ctrl;
    int         nsym;
    int         delta;
  } row_t;

  localparam int num_rows  = 20;
  localparam int ack_limit = 16;
  localparam int out_limit = 64;

  // CTRL value, sym_en_i strobes, expected out_en_o pulses
  localparam row_t rows [num_rows] = '{
    '{9'h000, 48, 48},   // NRZ-L
    '{9'h001, 48, 48},   // NRZ-M
    '{9'h002, 48, 48},   // NRZ-S
    '{9'h020, 48, 48},   // NRZ-L, swap
    '{9'h021, 48, 48},   // NRZ-M, swap
    '{9'h022, 48, 48},   // NRZ-S, swap
    '{9'h100, 64, 32},   // Biphase, NRZ-L
    '{9'h101, 64, 32},   // Biphase, NRZ-M
    '{9'h040, 32, 64},   // QPSK demux
    '{9'h060, 32, 64},   // QPSK demux, swap
    '{9'h004, 64, 64},   // RNRZ9
    '{9'h008, 64, 64},   // RNRZ11
    '{9'h00c, 64, 64},   // RNRZ15
    '{9'h010, 64, 64},   // RNRZ17
    '{9'h014, 64, 64},   // RNRZ23
    '{9'h084, 64, 64},
    '{9'h088, 64, 64},
    '{9'h08c, 64, 64},
    '{9'h090, 64, 64},
    '{9'h094, 64, 64}    // RNRZ23, inverted
  };

  logic                   clk;
  logic                   reset;
  logic                   wb_cyc_i;
  logic                   wb_stb_i;
  logic                   wb_we_i;
  logic [3:0]             wb_sel_i;
  logic [`DEC_ADDR_W-1:0] wb_adr_i;
  logic [31:0]            wb_dat_i;
  logic [31:0]            wb_dat_o;
  logic                   wb_ack_o;
  logic                   sym_en_i;
  logic                   sym2x_en_i;
  logic                   sym_i_i;
  logic                   sym_q_i;
  logic                   dout_i_o;
  logic                   dout_q_o;
  logic                   out_en_o;

  integer seed;
  int     errors;
  int     checks;
  logic   timed_out;
  logic   stim_i [0:127];
  logic   stim_q [0:127];
  logic   seen_i [$];
  logic   seen_q [$];

  decoder_top i_dut (
    .clk(clk), .reset(reset),
    .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
    .wb_sel_i(wb_sel_i), .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i),
    .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
    .sym_en_i(sym_en_i), .sym2x_en_i(sym2x_en_i), .sym_i_i(sym_i_i), .sym_q_i(sym_q_i),
    .dout_i_o(dout_i_o), .dout_q_o(dout_q_o), .out_en_o(out_en_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Output bits captured mid-cycle
  always @(negedge clk) begin
    if (out_en_o === 1'b1) begin
      seen_i.push_back(dout_i_o);
      seen_q.push_back(dout_q_o);
    end
  end

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
    end
  endtask

  // --------------------------------------------------
  // Wishbone classic master
  // --------------------------------------------------
  task automatic bus_cycle(input logic we, input logic [31:0] byte_adr,
                           input logic [31:0] wdata, input logic [3:0] sel,
                           output logic [31:0] rdata);
    int waits;
    waits = 0;
    rdata = '0;
    if (!timed_out) begin
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      wb_we_i  = we;
      wb_sel_i = sel;
      wb_adr_i = byte_adr[`DEC_ADDR_W+1:2];
      wb_dat_i = wdata;
      while (wb_ack_o !== 1'b1 && waits < ack_limit) begin
        @(posedge clk);
        #10;
        waits++;
      end
      if (wb_ack_o !== 1'b1) begin
        $display("Timeout: no Wishbone ack for address 0x%0h", byte_adr);
        timed_out = 1'b1;
      end else begin
        rdata = wb_dat_o;
        check_value("ack latency in cycles", waits, 32'd1);
      end
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
      // The cycle ends at the clock edge that samples ack
      @(posedge clk);
      #10;
    end
  endtask

  task automatic write_reg(input logic [31:0] byte_adr, input logic [31:0] wdata,
                           input logic [3:0] sel);
    logic [31:0] unused;
    bus_cycle(1'b1, byte_adr, wdata, sel, unused);
  endtask

  task automatic read_reg(input logic [31:0] byte_adr, output logic [31:0] rdata);
    bus_cycle(1'b0, byte_adr, 32'd0, 4'b1111, rdata);
  endtask

  // --------------------------------------------------
  // Symbol stream and reference model
  // --------------------------------------------------
  // Eight clocks per symbol with sym2x_en_i on clocks 0 and 4
  task automatic stream_symbols(input int n);
    int k;
    int c;
    if (!timed_out) begin
      for (k = 0; k < n; k++) begin
        for (c = 0; c < 8; c++) begin
          sym_en_i   = (c == 0);
          sym2x_en_i = (c == 0) || (c == 4);
          sym_i_i    = stim_i[k];
          sym_q_i    = stim_q[k];
          @(posedge clk);
          #10;
        end
      end
      sym_en_i   = 1'b0;
      sym2x_en_i = 1'b0;
    end
  endtask

  task automatic wait_for_outputs(input int n);
    int waits;
    waits = 0;
    if (!timed_out) begin
      while (seen_i.size() < n && waits < out_limit) begin
        @(posedge clk);
        #10;
        waits++;
      end
      if (seen_i.size() < n) begin
        $display("Timeout: only %0d of %0d out_en_o pulses arrived", seen_i.size(), n);
        timed_out = 1'b1;
      end
    end
  endtask

  function automatic logic line_decode(line_code_e code, logic cur, logic prev);
    case (code)
      LC_NRZM: return cur ^ prev;
      LC_NRZS: return ~(cur ^ prev);
      default: return cur;
    endcase
  endfunction

  function automatic logic [9:0] taps_for(derand_mode_e mode);
    case (mode)
      DR_RNRZ9:  return `DEC_TAPS_RNRZ9;
      DR_RNRZ11: return `DEC_TAPS_RNRZ11;
      DR_RNRZ15: return `DEC_TAPS_RNRZ15;
      DR_RNRZ17: return `DEC_TAPS_RNRZ17;
      default:   return `DEC_TAPS_RNRZ23;
    endcase
  endfunction

  // Output event m carries decoded bit m-1, or half of bit (m-2)/2 with demux
  task automatic check_row(input int r, input decoder_cfg_t cfg, input int nsym);
    logic       b_i [0:127];
    logic       b_q [0:127];
    logic       s_i [0:255];
    logic       s_q [0:255];
    logic       s_ok [0:255];
    logic       f;
    logic       o;
    logic       e_i;
    logic       e_q;
    logic [9:0] taps;
    int         nbits;
    int         nevt;
    int         lag;
    int         settle;
    int         j;
    int         m;
    nbits  = cfg.biphase ? nsym / 2 : nsym;
    nevt   = cfg.demux ? 2 * nbits : nbits;
    lag    = cfg.demux ? 2 : 1;
    settle = (cfg.derand == DR_OFF) ? 8 : 32;
    taps   = taps_for(cfg.derand);
    for (m = 0; m < 256; m++) begin
      s_ok[m] = 1'b0;
    end
    // Biphase keeps the first half-symbol of each bit
    for (j = 0; j < nbits; j++) begin
      b_i[j] = cfg.biphase ? stim_i[2 * j] : stim_i[j];
      b_q[j] = cfg.biphase ? stim_q[2 * j] : stim_q[j];
    end
    for (j = 1; j < nbits; j++) begin
      f = line_decode(cfg.line_code, b_i[j], b_i[j - 1]);
      o = line_decode(cfg.line_code, b_q[j], b_q[j - 1]);
      if (cfg.swap) begin
        {f, o} = {o, f};
      end
      if (cfg.demux) begin
        m = 2 * j + lag;
        if (m + 1 < nevt) begin
          {s_i[m], s_q[m], s_ok[m]} = {f ^ cfg.invert, f ^ cfg.invert, 1'b1};
          {s_i[m + 1], s_q[m + 1], s_ok[m + 1]} = {o ^ cfg.invert, o ^ cfg.invert, 1'b1};
        end
      end else begin
        m = j + lag;
        if (m < nevt) begin
          {s_i[m], s_q[m], s_ok[m]} = {f ^ cfg.invert, o ^ cfg.invert, 1'b1};
        end
      end
    end
    for (m = settle; m < nevt; m++) begin
      if (s_ok[m]) begin
        e_i = s_i[m];
        e_q = s_q[m];
        // Descrambled bit is the I lane XOR its two tap stages, on both lanes
        if (cfg.derand != DR_OFF) begin
          e_i = s_i[m] ^ s_i[m - taps[9:5]] ^ s_i[m - taps[4:0]];
          e_q = e_i;
        end
        check_value($sformatf("row %0d output pair %0d", r, m),
                    {30'd0, seen_i[m], seen_q[m]}, {30'd0, e_i, e_q});
      end
    end
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    logic [31:0]  rd;
    decoder_cfg_t cfg;
    integer       rnd;
    int           r;
    int           k;
    seed       = 57;
    errors     = 0;
    checks     = 0;
    timed_out  = 1'b0;
    reset      = 1'b1;
    wb_cyc_i   = 1'b0;
    wb_stb_i   = 1'b0;
    wb_we_i    = 1'b0;
    wb_sel_i   = 4'b0000;
    wb_adr_i   = '0;
    wb_dat_i   = 32'd0;
    sym_en_i   = 1'b0;
    sym2x_en_i = 1'b0;
    sym_i_i    = 1'b0;
    sym_q_i    = 1'b0;
    repeat (8) @(posedge clk);
    #10;
    reset = 1'b0;
    check_value("ack and outputs after reset",
                {28'd0, wb_ack_o, out_en_o, dout_i_o, dout_q_o}, 32'd0);
    read_reg(`DEC_REG_CTRL, rd);
    check_value("CTRL after reset", rd, 32'd0);
    read_reg(`DEC_REG_COUNT, rd);
    check_value("COUNT after reset", rd, 32'd0);

    // Lane 0 holds bits 7:0 and lane 1 holds bit 8
    write_reg(`DEC_REG_CTRL, 32'h0000_01a5, 4'b1111);
    read_reg(`DEC_REG_CTRL, rd);
    check_value("CTRL full write", rd, 32'h1a5);
    write_reg(`DEC_REG_CTRL, 32'h0000_0000, 4'b0001);
    read_reg(`DEC_REG_CTRL, rd);
    check_value("CTRL lane 0 write", rd, 32'h100);
    write_reg(`DEC_REG_CTRL, 32'hffff_ff3c, 4'b1100);
    read_reg(`DEC_REG_CTRL, rd);
    check_value("CTRL upper lanes write", rd, 32'h100);
    write_reg(`DEC_REG_CTRL, 32'h0000_fec3, 4'b0011);
    write_reg(32'h8, 32'hffff_ffff, 4'b1111);
    read_reg(`DEC_REG_CTRL, rd);
    check_value("CTRL after unmapped write", rd, 32'h0c3);
    read_reg(32'hc, rd);
    check_value("unmapped read", rd, 32'd0);

    for (r = 0; r < num_rows && !timed_out; r++) begin
      cfg = decoder_cfg_t'(rows[r].ctrl);
      for (k = 0; k < rows[r].nsym; k++) begin
        rnd      = $random(seed);
        stim_i[k] = rnd[0];
        stim_q[k] = rnd[1];
      end
      write_reg(`DEC_REG_CTRL, {23'd0, rows[r].ctrl}, 4'b1111);
      // Flush restarts the biphase phase before the first strobe
      @(posedge clk);
      #10;
      seen_i.delete();
      seen_q.delete();
      stream_symbols(rows[r].nsym);
      wait_for_outputs(rows[r].delta);
      if (!timed_out) begin
        check_value($sformatf("row %0d out_en_o pulses", r), seen_i.size(), rows[r].delta);
        check_row(r, cfg, rows[r].nsym);
        read_reg(`DEC_REG_COUNT, rd);
        check_value($sformatf("row %0d bit counter", r), rd, rows[r].delta);
      end
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* decoder/decoder_top.sv */
// Top level of the PCM symbol decoder
// Host registers on plain Wishbone ports; hard I/Q symbols in, NRZ-L bits out
// with out_en_o marking each new output bit
`include "decoder_cfg.svh"

module decoder_top (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   wb_cyc_i,
  input  logic                   wb_stb_i,
  input  logic                   wb_we_i,
  input  logic [3:0]             wb_sel_i,
  input  logic [`DEC_ADDR_W-1:0] wb_adr_i,
  input  logic [31:0]            wb_dat_i,
  output logic [31:0]            wb_dat_o,
  output logic                   wb_ack_o,
  input  logic                   sym_en_i,
  input  logic                   sym2x_en_i,
  input  logic                   sym_i_i,
  input  logic                   sym_q_i,
  output logic                   dout_i_o,
  output logic                   dout_q_o,
  output logic                   out_en_o
);
  import decoder_pkg::*;

  decoder_cfg_t cfg;
  logic         flush;
  logic         nrz_i;
  logic         nrz_q;
  logic         bit_en;
  logic         dec_i;
  logic         dec_q;
  logic         sel_i;
  logic         sel_q;
  logic         sel_en;

  // --------------------------------------------------
  // Host bus, master side driven from the ports
  // --------------------------------------------------
  wb_if wb_bus ();

  assign wb_bus.cyc   = wb_cyc_i;
  assign wb_bus.stb   = wb_stb_i;
  assign wb_bus.we    = wb_we_i;
  assign wb_bus.sel   = wb_sel_i;
  assign wb_bus.adr   = wb_adr_i;
  assign wb_bus.dat_w = wb_dat_i;
  assign wb_dat_o     = wb_bus.dat_r;
  assign wb_ack_o     = wb_bus.ack;

  decoder_regs i_regs (
    .clk(clk), .reset(reset), .wb(wb_bus.slave),
    .out_en_i(out_en_o), .cfg_o(cfg), .flush_o(flush)
  );

  // --------------------------------------------------
  // Bit pipeline
  // --------------------------------------------------
  biphase_to_nrz i_biphase (
    .clk(clk), .reset(reset), .cfg_i(cfg), .flush_i(flush),
    .sym_en_i(sym_en_i), .sym_i_i(sym_i_i), .sym_q_i(sym_q_i),
    .nrz_i_o(nrz_i), .nrz_q_o(nrz_q), .bit_en_o(bit_en)
  );

  mark_space_decode i_msd_i (
    .clk(clk), .reset(reset), .cfg_i(cfg),
    .en_i(bit_en), .bit_i(nrz_i), .bit_o(dec_i)
  );

  mark_space_decode i_msd_q (
    .clk(clk), .reset(reset), .cfg_i(cfg),
    .en_i(bit_en), .bit_i(nrz_q), .bit_o(dec_q)
  );

  iq_output_select i_select (
    .clk(clk), .reset(reset), .cfg_i(cfg),
    .sym2x_en_i(sym2x_en_i), .sym_en_i(sym_en_i), .bit_en_i(bit_en),
    .dec_i_i(dec_i), .dec_q_i(dec_q),
    .sel_i_o(sel_i), .sel_q_o(sel_q), .sel_en_o(sel_en)
  );

  derandomizer i_derand (
    .clk(clk), .reset(reset), .cfg_i(cfg),
    .sel_i_i(sel_i), .sel_q_i(sel_q), .sel_en_i(sel_en),
    .dout_i_o(dout_i_o), .dout_q_o(dout_q_o), .out_en_o(out_en_o)
  );

endmodule

/* decoder/derandomizer.sv */
// Self-synchronizing RNRZ derandomizer, last stage of the decoder
// The I lane feeds a 23-stage history; both outputs carry the descrambled bit.
// With derandomizing off the lanes are registered as they are
`include "decoder_cfg.svh"

module derandomizer (
  input  logic                      clk,
  input  logic                      reset,
  input  decoder_pkg::decoder_cfg_t cfg_i,
  input  logic                      sel_i_i,
  input  logic                      sel_q_i,
  input  logic                      sel_en_i,
  output logic                      dout_i_o,
  output logic                      dout_q_o,
  output logic                      out_en_o
);
  import decoder_pkg::*;

  logic [22:0] hist_q;
  logic [9:0]  taps;
  logic        tap_xor;
  logic        dout_i_q;
  logic        dout_q_q;
  logic        out_en_q;

  // --------------------------------------------------
  // Tap selection
  // --------------------------------------------------
  always_comb begin
    case (cfg_i.derand)
      DR_RNRZ9:  taps = `DEC_TAPS_RNRZ9;
      DR_RNRZ11: taps = `DEC_TAPS_RNRZ11;
      DR_RNRZ17: taps = `DEC_TAPS_RNRZ17;
      DR_RNRZ23: taps = `DEC_TAPS_RNRZ23;
      default:   taps = `DEC_TAPS_RNRZ15;
    endcase
  end

  // Stage n sits at hist_q[n-1]
  assign tap_xor = hist_q[taps[9:5] - 5'd1] ^ hist_q[taps[4:0] - 5'd1];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      hist_q   <= '0;
      out_en_q <= 1'b0;
      dout_i_q <= 1'b0;
      dout_q_q <= 1'b0;
    end else begin
      out_en_q <= sel_en_i;
      if (sel_en_i) begin
        if (cfg_i.derand != DR_OFF) begin
          hist_q   <= {hist_q[21:0], sel_i_i};
          dout_i_q <= sel_i_i ^ tap_xor;
          dout_q_q <= sel_i_i ^ tap_xor;
        end else begin
          // Same register delay as the derandomized path
          dout_i_q <= sel_i_i;
          dout_q_q <= sel_q_i;
        end
      end
    end
  end

  assign dout_i_o = dout_i_q;
  assign dout_q_o = dout_q_q;
  assign out_en_o = out_en_q;

endmodule

/* decoder/iq_output_select.sv */
// Output lane selection for the decoder
// QPSK demux serializes I and Q at the double rate; otherwise the pair is
// passed at the bit rate. Swap and inversion apply in both cases
module iq_output_select (
  input  logic                      clk,
  input  logic                      reset,
  input  decoder_pkg::decoder_cfg_t cfg_i,
  input  logic                      sym2x_en_i,
  input  logic                      sym_en_i,
  input  logic                      bit_en_i,
  input  logic                      dec_i_i,
  input  logic                      dec_q_i,
  output logic                      sel_i_o,
  output logic                      sel_q_o,
  output logic                      sel_en_o
);

  logic sel_i_q;
  logic sel_q_q;
  logic sel_en_q;
  logic phase_q;
  logic hold_q;
  logic second;
  logic first_bit;
  logic other_bit;
  logic adv;

  // Lane order after swap
  assign first_bit = cfg_i.swap ? dec_q_i : dec_i_i;
  assign other_bit = cfg_i.swap ? dec_i_i : dec_q_i;

  // A symbol strobe always starts a new pair
  assign second = sym_en_i ? 1'b0 : phase_q;
  assign adv    = cfg_i.demux ? sym2x_en_i : bit_en_i;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      phase_q  <= 1'b0;
      sel_en_q <= 1'b0;
      hold_q   <= 1'b0;
      sel_i_q  <= 1'b0;
      sel_q_q  <= 1'b0;
    end else begin
      sel_en_q <= adv;
      if (sym2x_en_i) begin
        phase_q <= ~second;
      end
      if (adv) begin
        if (cfg_i.demux) begin
          // --------------------------------------------------
          // Serial stream, same bit on both lanes
          // --------------------------------------------------
          if (second) begin
            sel_i_q <= hold_q ^ cfg_i.invert;
            sel_q_q <= hold_q ^ cfg_i.invert;
          end else begin
            // Keep the partner lane so both halves come from one symbol
            hold_q  <= other_bit;
            sel_i_q <= first_bit ^ cfg_i.invert;
            sel_q_q <= first_bit ^ cfg_i.invert;
          end
        end else begin
          sel_i_q <= first_bit ^ cfg_i.invert;
          sel_q_q <= other_bit ^ cfg_i.invert;
        end
      end
    end
  end

  assign sel_i_o  = sel_i_q;
  assign sel_q_o  = sel_q_q;
  assign sel_en_o = sel_en_q;

endmodule

/* decoder/mark_space_decode.sv */
// Differential decoder for one lane; NRZ-M and NRZ-S back to NRZ-L
// Instantiated once per lane, advancing on the NRZ bit strobe
module mark_space_decode (
  input  logic                      clk,
  input  logic                      reset,
  input  decoder_pkg::decoder_cfg_t cfg_i,
  input  logic                      en_i,
  input  logic                      bit_i,
  output logic                      bit_o
);
  import decoder_pkg::*;

  logic prev_q;
  logic bit_q;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      prev_q <= 1'b0;
      bit_q  <= 1'b0;
    end else if (en_i) begin
      prev_q <= bit_i;
      case (cfg_i.line_code)
        // A transition marks a one
        LC_NRZM: bit_q <= bit_i ^ prev_q;
        // No transition marks a one
        LC_NRZS: bit_q <= ~(bit_i ^ prev_q);
        default: bit_q <= bit_i;
      endcase
    end
  end

  assign bit_o = bit_q;

endmodule

/* decoder/biphase_to_nrz.sv */
// First decoder stage; turns biphase-L half-symbols into NRZ bits
// In biphase mode the first half of each bit is kept on I and Q is sampled
// at the same boundary. Otherwise both lanes are registered on every strobe
module biphase_to_nrz (
  input  logic                      clk,
  input  logic                      reset,
  input  decoder_pkg::decoder_cfg_t cfg_i,
  input  logic                      flush_i,
  input  logic                      sym_en_i,
  input  logic                      sym_i_i,
  input  logic                      sym_q_i,
  output logic                      nrz_i_o,
  output logic                      nrz_q_o,
  output logic                      bit_en_o
);

  logic nrz_i_q;
  logic nrz_q_q;
  logic bit_en_q;
  // High while waiting for the second half of a biphase bit
  logic half_q;
  logic take;

  // First half-symbol of a bit, or every strobe outside biphase mode
  assign take = sym_en_i & (~cfg_i.biphase | ~half_q);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      half_q   <= 1'b0;
      bit_en_q <= 1'b0;
      nrz_i_q  <= 1'b0;
      nrz_q_q  <= 1'b0;
    end else begin
      bit_en_q <= take;
      if (flush_i) begin
        half_q <= 1'b0;
      end else if (sym_en_i & cfg_i.biphase) begin
        half_q <= ~half_q;
      end
      if (take) begin
        nrz_i_q <= sym_i_i;
        nrz_q_q <= sym_q_i;
      end
    end
  end

  assign nrz_i_o  = nrz_i_q;
  assign nrz_q_o  = nrz_q_q;
  assign bit_en_o = bit_en_q;

endmodule

/* decoder/decoder_regs.sv */
// Wishbone classic slave for the decoder control register and bit counter
// Ack follows a request by one clock; writing CTRL clears the counter
// and pulses flush to the datapath
`include "decoder_cfg.svh"

module decoder_regs (
  input  logic                      clk,
  input  logic                      reset,
  wb_if.slave                       wb,
  input  logic                      out_en_i,
  output decoder_pkg::decoder_cfg_t cfg_o,
  output logic                      flush_o
);
  import decoder_pkg::*;

  localparam logic [`DEC_ADDR_W+1:0] ctrl_ofs  = `DEC_REG_CTRL;
  localparam logic [`DEC_ADDR_W+1:0] count_ofs = `DEC_REG_COUNT;

  logic [8:0]             ctrl_q;
  logic [31:0]            count_q;
  logic [31:0]            dat_r_q;
  logic                   ack_q;
  logic                   flush_q;
  logic                   take;
  logic                   wr_ctrl;
  logic                   hit_ctrl;
  logic                   hit_count;
  logic [`DEC_ADDR_W+1:0] byte_adr;

  // --------------------------------------------------
  // Request decode
  // --------------------------------------------------
  // One ack per request, even if stb stays up during the ack cycle
  assign take      = wb.cyc & wb.stb & ~ack_q;
  assign byte_adr  = {wb.adr, 2'b00};
  assign hit_ctrl  = (byte_adr == ctrl_ofs);
  assign hit_count = (byte_adr == count_ofs);
  assign wr_ctrl   = take & wb.we & hit_ctrl;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ack_q   <= 1'b0;
      flush_q <= 1'b0;
      ctrl_q  <= '0;
      count_q <= '0;
    end else begin
      ack_q   <= take;
      flush_q <= wr_ctrl;
      if (wr_ctrl) begin
        // Byte lanes 0 and 1 hold the nine control bits
        if (wb.sel[0]) begin
          ctrl_q[7:0] <= wb.dat_w[7:0];
        end
        if (wb.sel[1]) begin
          ctrl_q[8] <= wb.dat_w[8];
        end
        count_q <= '0;
      end else if (out_en_i) begin
        count_q <= count_q + 32'd1;
      end
    end
  end

  // Read data, valid with ack
  always_ff @(posedge clk) begin
    if (take & ~wb.we) begin
      if (hit_ctrl) begin
        dat_r_q <= {23'd0, ctrl_q};
      end else if (hit_count) begin
        dat_r_q <= count_q;
      end else begin
        dat_r_q <= '0;
      end
    end
  end

  assign wb.ack   = ack_q;
  assign wb.dat_r = dat_r_q;
  assign cfg_o    = decoder_cfg_t'(ctrl_q);
  assign flush_o  = flush_q;

endmodule

/* common/wb_if.sv */
// Wishbone classic bus between the decoder top level and its register block
// The top level drives the master side, the register block the slave side
`include "decoder_cfg.svh"

interface wb_if;

  logic                   cyc;
  logic                   stb;
  logic                   we;
  logic [3:0]             sel;
  logic [`DEC_ADDR_W-1:0] adr;
  logic [31:0]            dat_w;
  logic [31:0]            dat_r;
  logic                   ack;

  modport master (
    output cyc, stb, we, sel, adr, dat_w,
    input  dat_r, ack
  );

  modport slave (
    input  cyc, stb, we, sel, adr, dat_w,
    output dat_r, ack
  );

endinterface

/* common/decoder_pkg.sv */
// Shared types for the PCM symbol decoder
// The control register layout is defined here once as decoder_cfg_t
package decoder_pkg;

  // Differential line codes on each lane
  typedef enum logic [1:0] {
    LC_NRZL = 2'd0,
    LC_NRZM = 2'd1,
    LC_NRZS = 2'd2
  } line_code_e;

  // Derandomizer polynomial selection
  typedef enum logic [2:0] {
    DR_OFF    = 3'd0,
    DR_RNRZ9  = 3'd1,
    DR_RNRZ11 = 3'd2,
    DR_RNRZ15 = 3'd3,
    DR_RNRZ17 = 3'd4,
    DR_RNRZ23 = 3'd5
  } derand_mode_e;

  // --------------------------------------------------
  // CTRL register fields, MSB first
  // --------------------------------------------------
  typedef struct packed {
    logic         biphase;    // bit 8
    logic         invert;     // bit 7
    logic         demux;      // bit 6
    logic         swap;       // bit 5
    derand_mode_e derand;     // bits 4:2
    line_code_e   line_code;  // bits 1:0
  } decoder_cfg_t;

endpackage

/* common/decoder_cfg.svh */
// Build-time constants for the PCM symbol decoder
// Include wherever the bus width, register map or RNRZ taps are needed
`ifndef DECODER_CFG_SVH
`define DECODER_CFG_SVH

// Wishbone word address width
`define DEC_ADDR_W 4

// Register byte offsets
`define DEC_REG_CTRL  'h0
`define DEC_REG_COUNT 'h4

// RNRZ tap stage pairs, counted from 1
// Packed as {first stage, second stage}, 5 bits each
`define DEC_TAPS_RNRZ9  {5'd9, 5'd5}
`define DEC_TAPS_RNRZ11 {5'd11, 5'd9}
`define DEC_TAPS_RNRZ15 {5'd15, 5'd14}
`define DEC_TAPS_RNRZ17 {5'd17, 5'd14}
`define DEC_TAPS_RNRZ23 {5'd23, 5'd18}

`endif
